// ==== rtl/cache_settings.svh ====
// fixed geometry; word and line sizes and set count must be powers of two, two ways assumed
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define CACHE_ADDR_W     32 // byte address
`define CACHE_WORD_W     32
`define CACHE_LINE_WORDS 4
`define CACHE_SETS       8  // per way

// derived address fields
`define CACHE_BYTE_OFF_W ($clog2(`CACHE_WORD_W / 8))
`define CACHE_WORD_SEL_W ($clog2(`CACHE_LINE_WORDS))
`define CACHE_INDEX_W    ($clog2(`CACHE_SETS))
`define CACHE_TAG_W      (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_WORD_SEL_W - `CACHE_BYTE_OFF_W)

`define CACHE_LINE_W     (`CACHE_WORD_W * `CACHE_LINE_WORDS)

`endif

// ==== rtl/cache_pkg.sv ====
// types for a read-only two-way cache; field widths come from the shared defines header
`include "cache_settings.svh"

package cache_pkg;

   typedef logic [`CACHE_TAG_W-1:0]      tag_t;
   typedef logic [`CACHE_INDEX_W-1:0]    index_t;
   typedef logic [`CACHE_WORD_SEL_W-1:0] word_sel_t; // word inside a line
   typedef logic [`CACHE_WORD_W-1:0]     word_t;
   typedef logic [`CACHE_LINE_W-1:0]     line_t;

   // decoded cpu request
   typedef struct packed {
      tag_t      tag;
      index_t    index;
      word_sel_t word_sel;
   } req_t;

   // array read results for both ways, bit 1 is way 1
   typedef struct packed {
      req_t        req;
      tag_t [1:0]  tags;
      logic [1:0]  valid;
      line_t [1:0] lines;
   } lookup_t;

   // line install into the victim way
   typedef struct packed {
      logic   write;
      logic   way;
      index_t index;
      tag_t   tag;
      line_t  line;
   } fill_t;

   typedef enum logic [1:0] {idle, fetch, wait_word, install} refill_state_t;

endpackage

// ==== rtl/sram_array.sv ====
// single port, read data one cycle after the address edge, no reset on contents
`timescale 1ns/1ps

module sram_array #(
   parameter int width = 32,
   parameter int depth = 8
) (
   input  logic              clk,
   input  cache_pkg::index_t addr,
   input  logic [width-1:0]  wdata,
   input  logic              we,
   output logic [width-1:0]  rdata
);

   logic [width-1:0]  mem [depth];
   cache_pkg::index_t addr_q;

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      addr_q <= addr; // read of the written entry sees new data
   end

   assign rdata = mem[addr_q];

endmodule

// ==== rtl/cache_lookup.sv ====
// accepts one request at a time; installs and new requests never overlap
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_lookup (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    ce,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  logic                    busy,
   output logic                    ready,
   input  cache_pkg::fill_t        fill,
   output cache_pkg::index_t       array_addr,
   input  cache_pkg::tag_t [1:0]   tags,
   input  cache_pkg::line_t [1:0]  lines,
   output cache_pkg::lookup_t      lookup,
   output logic                    lookup_valid
);

   import cache_pkg::*;

   req_t                         req_in;
   req_t                         req_q;
   logic                         accept;
   logic [1:0][`CACHE_SETS-1:0]  valid_q; // one bit per way per set

   // split the byte address; byte offset bits are ignored
   assign req_in.tag      = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
   assign req_in.index    = addr[`CACHE_BYTE_OFF_W + `CACHE_WORD_SEL_W +: `CACHE_INDEX_W];
   assign req_in.word_sel = addr[`CACHE_BYTE_OFF_W +: `CACHE_WORD_SEL_W];

   assign ready  = !lookup_valid && !busy;
   assign accept = ce && ready;

   // install owns the arrays, otherwise the incoming address
   assign array_addr = fill.write ? fill.index : req_in.index;

   always_ff @(posedge clk) begin
      if (reset) begin
         lookup_valid <= 1'b0;
         valid_q      <= '0;
      end else begin
         lookup_valid <= accept;
         if (fill.write) begin
            valid_q[fill.way][fill.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= req_in;
      end
   end

   always_comb begin
      lookup.req   = req_q;
      lookup.tags  = tags;
      lookup.lines = lines;
      lookup.valid = {valid_q[1][req_q.index], valid_q[0][req_q.index]};
   end

endmodule

// ==== rtl/cache_hit_select.sv ====
// one LRU bit per set; response holds until taken, nothing new accepted meanwhile
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_hit_select (
   input  logic               clk,
   input  logic               reset,
   input  cache_pkg::lookup_t lookup,
   input  logic               lookup_valid,
   input  logic               fill_done,
   input  cache_pkg::word_t   fill_word,
   input  logic               rdata_ready,
   output cache_pkg::word_t   rdata,
   output logic               rdata_valid,
   output logic               busy,
   output logic               miss_start,
   output cache_pkg::req_t    miss_req,
   output logic               victim
);

   import cache_pkg::*;

   logic [1:0]             hit;
   logic                   hit_way;
   line_t                  hit_line;
   word_t                  hit_word;
   logic                   new_victim;
   logic                   miss_wait; // refill in progress
   logic [`CACHE_SETS-1:0] lru;       // way to replace next

   always_comb begin
      for (int w = 0; w < 2; w++) begin
         hit[w] = lookup.valid[w] && (lookup.tags[w] == lookup.req.tag);
      end
   end

   assign hit_way  = hit[1];
   assign hit_line = lookup.lines[hit_way];
   assign hit_word = hit_line[lookup.req.word_sel * `CACHE_WORD_W +: `CACHE_WORD_W];

   // empty way first, way 0 before way 1
   always_comb begin
      if (!lookup.valid[0]) begin
         new_victim = 1'b0;
      end else if (!lookup.valid[1]) begin
         new_victim = 1'b1;
      end else begin
         new_victim = lru[lookup.req.index];
      end
   end

   assign busy = rdata_valid || miss_wait;

   always_ff @(posedge clk) begin
      if (reset) begin
         rdata_valid <= 1'b0;
         miss_wait   <= 1'b0;
         miss_start  <= 1'b0;
         lru         <= '0;
      end else begin
         miss_start <= 1'b0;
         if (rdata_valid && rdata_ready) begin
            rdata_valid <= 1'b0;
         end
         if (lookup_valid) begin
            if (|hit) begin
               rdata_valid              <= 1'b1;
               lru[lookup.req.index]    <= ~hit_way;
            end else begin
               miss_start <= 1'b1;
               miss_wait  <= 1'b1;
            end
         end
         if (fill_done) begin
            rdata_valid         <= 1'b1;
            miss_wait           <= 1'b0;
            lru[miss_req.index] <= ~victim; // filled way is now most recent
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lookup_valid && |hit) begin
         rdata <= hit_word;
      end else if (fill_done) begin
         rdata <= fill_word;
      end
      if (lookup_valid && !(|hit)) begin
         miss_req <= lookup.req;
         victim   <= new_victim;
      end
   end

endmodule

// ==== rtl/cache_refill.sv ====
// fetches a whole line in order from word 0; one memory read outstanding at a time
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_refill (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     miss_start,
   input  cache_pkg::req_t          miss_req,
   input  logic                     victim,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic                     mem_ce,
   input  cache_pkg::word_t         mem_rdata,
   input  logic                     mem_rdata_valid,
   output cache_pkg::fill_t         fill,
   output logic                     fill_done,
   output cache_pkg::word_t         fill_word
);

   import cache_pkg::*;

   refill_state_t state;
   word_sel_t     count; // word being fetched
   req_t          req_q;
   logic          way_q;
   line_t         line_buf;
   logic          last_word;

   assign last_word = (count == word_sel_t'(`CACHE_LINE_WORDS - 1));

   assign mem_ce   = (state == fetch);
   assign mem_addr = {req_q.tag, req_q.index, count, {`CACHE_BYTE_OFF_W{1'b0}}};

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= idle;
         count     <= '0;
         fill_done <= 1'b0;
      end else begin
         fill_done <= 1'b0;
         case (state)
            idle: begin
               if (miss_start) begin
                  count <= '0;
                  state <= fetch;
               end
            end
            fetch: state <= wait_word; // strobe lasts one cycle
            wait_word: begin
               if (mem_rdata_valid) begin
                  if (last_word) begin
                     state <= install;
                  end else begin
                     count <= count + 1'b1;
                     state <= fetch;
                  end
               end
            end
            install: begin
               fill_done <= 1'b1;
               state     <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == idle && miss_start) begin
         req_q <= miss_req;
         way_q <= victim;
      end
      if (state == wait_word && mem_rdata_valid) begin
         line_buf[count * `CACHE_WORD_W +: `CACHE_WORD_W] <= mem_rdata;
      end
   end

   always_comb begin
      fill.write = (state == install);
      fill.way   = way_q;
      fill.index = req_q.index;
      fill.tag   = req_q.tag;
      fill.line  = line_buf;
   end

   // word the cpu asked for, valid from install on
   assign fill_word = line_buf[req_q.word_sel * `CACHE_WORD_W +: `CACHE_WORD_W];

endmodule

// ==== rtl/icache_top.sv ====
// read-only two-way cache; hit answers two edges after acceptance, no flush or error path
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ce,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   output logic                     ready,
   output cache_pkg::word_t         rdata,
   output logic                     rdata_valid,
   input  logic                     rdata_ready,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic                     mem_ce,
   input  cache_pkg::word_t         mem_rdata,
   input  logic                     mem_rdata_valid
);

   import cache_pkg::*;

   logic        busy;
   logic        lookup_valid;
   logic        miss_start;
   logic        victim;
   logic        fill_done;
   lookup_t     lookup;
   req_t        miss_req;
   fill_t       fill;
   word_t       fill_word;
   index_t      array_addr;
   tag_t [1:0]  way_tags;
   line_t [1:0] way_lines;

   cache_lookup lookup_i (
      .clk          (clk),
      .reset        (reset),
      .ce           (ce),
      .addr         (addr),
      .busy         (busy),
      .ready        (ready),
      .fill         (fill),
      .array_addr   (array_addr),
      .tags         (way_tags),
      .lines        (way_lines),
      .lookup       (lookup),
      .lookup_valid (lookup_valid)
   );

   cache_hit_select hit_select_i (
      .clk          (clk),
      .reset        (reset),
      .lookup       (lookup),
      .lookup_valid (lookup_valid),
      .fill_done    (fill_done),
      .fill_word    (fill_word),
      .rdata_ready  (rdata_ready),
      .rdata        (rdata),
      .rdata_valid  (rdata_valid),
      .busy         (busy),
      .miss_start   (miss_start),
      .miss_req     (miss_req),
      .victim       (victim)
   );

   cache_refill refill_i (
      .clk             (clk),
      .reset           (reset),
      .miss_start      (miss_start),
      .miss_req        (miss_req),
      .victim          (victim),
      .mem_addr        (mem_addr),
      .mem_ce          (mem_ce),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .fill            (fill),
      .fill_done       (fill_done),
      .fill_word       (fill_word)
   );

   // tag and line arrays per way, written only during install
   for (genvar w = 0; w < 2; w++) begin : g_way
      logic way_we;

      assign way_we = fill.write && (fill.way == 1'(w));

      sram_array #(.width(`CACHE_TAG_W), .depth(`CACHE_SETS)) tag_ram_i (
         .clk   (clk),
         .addr  (array_addr),
         .wdata (fill.tag),
         .we    (way_we),
         .rdata (way_tags[w])
      );

      sram_array #(.width(`CACHE_LINE_W), .depth(`CACHE_SETS)) line_ram_i (
         .clk   (clk),
         .addr  (array_addr),
         .wdata (fill.line),
         .we    (way_we),
         .rdata (way_lines[w])
      );
   end

endmodule

// ==== sim/clock_gen.sv ====
// clk period and reset length are fixed by parameters; reset is power-on pulse or reset_req
`timescale 1ns/1ps

module clock_gen #(
   parameter int period_ns    = 100,
   parameter int reset_cycles = 5
) (
   input  logic reset_req,
   output logic clk,
   output logic reset
);

   logic por = 1'b1; // power-on reset

   initial clk = 1'b0;

   always #(period_ns / 2) clk = ~clk;

   initial begin
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      por <= 1'b0;
   end

   assign reset = por || reset_req;

endmodule

// ==== sim/icache_assertions.sv ====
// handshake and memory strobe checks for icache_top; fail_count is read by the testbench at the end
`timescale 1ns/1ps

module icache_assertions (
   input logic             clk,
   input logic             reset,
   input logic             ready,
   input cache_pkg::word_t rdata,
   input logic             rdata_valid,
   input logic             rdata_ready,
   input logic             mem_ce,
   input logic             mem_rdata_valid
);

   int unsigned fail_count = 0;
   logic        mem_busy; // memory read outstanding

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_busy <= 1'b0;
      end else if (mem_ce) begin
         mem_busy <= 1'b1;
      end else if (mem_rdata_valid) begin
         mem_busy <= 1'b0;
      end
   end

   // response holds while not taken
   assert property (@(posedge clk) disable iff (reset)
      (rdata_valid && !rdata_ready) |=> (rdata_valid && $stable(rdata)))
   else begin
      fail_count++;
      $error("rdata or rdata_valid changed under back-pressure");
   end

   assert property (@(posedge clk) disable iff (reset) mem_ce |-> !mem_busy)
   else begin
      fail_count++;
      $error("mem_ce raised again before mem_rdata_valid");
   end

   assert property (@(posedge clk) disable iff (reset) rdata_valid |-> !ready)
   else begin
      fail_count++;
      $error("ready high while rdata_valid is high");
   end

endmodule

bind icache_top icache_assertions assertions_i (.*);

// ==== sim/icache_tb.sv ====
// directed tests for icache_top; memory model answers each mem_ce after 1 to 4 cycles
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_tb;

   import cache_pkg::*;

   typedef logic [`CACHE_ADDR_W-1:0] addr_t;

   localparam int wait_limit = 100; // cycles allowed per wait loop

   logic   clk;
   logic   reset;
   logic   reset_req = 1'b0;
   logic   ce = 1'b0;
   addr_t  addr = '0;
   logic   ready;
   word_t  rdata;
   logic   rdata_valid;
   logic   rdata_ready = 1'b0;
   addr_t  mem_addr;
   logic   mem_ce;
   word_t  mem_rdata = '0;
   logic   mem_rdata_valid = 1'b0;

   integer seed = 96590;
   addr_t  seen_addr[$]; // mem_addr of every strobe since the last request
   logic   pending = 1'b0;
   int     delay = 0;
   addr_t  pend_addr = '0;

   clock_gen clock_gen_i (
      .reset_req (reset_req),
      .clk       (clk),
      .reset     (reset)
   );

   icache_top icache_top_i (
      .clk             (clk),
      .reset           (reset),
      .ce              (ce),
      .addr            (addr),
      .ready           (ready),
      .rdata           (rdata),
      .rdata_valid     (rdata_valid),
      .rdata_ready     (rdata_ready),
      .mem_addr        (mem_addr),
      .mem_ce          (mem_ce),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid)
   );

   // memory contents: word at byte address a
   function automatic word_t mem_word(input addr_t a);
      return word_t'(a * 3 + 1);
   endfunction

   task automatic end_in_failure();
      $display("Result: FAILED");
      $fatal(1, "stopped on first error");
   endtask

   task automatic report_failure(input string why);
      $display("ERROR at %0t: %s", $time, why);
      end_in_failure();
   endtask

   task automatic check_word(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s actual %h expected %h", $time, name, actual, expected);
         end_in_failure();
      end
   endtask

   task automatic check_count(input string name, input int actual, input int expected);
      if (actual != expected) begin
         $display("MISMATCH at %0t: %s actual %0d expected %0d", $time, name, actual, expected);
         end_in_failure();
      end
   endtask

   task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s actual %h expected %h", $time, name, actual, expected);
         end_in_failure();
      end
   endtask

   // behavioural memory, one read at a time
   always @(negedge clk) begin
      mem_rdata_valid = 1'b0;
      if (pending) begin
         if (delay == 1) begin
            mem_rdata       = mem_word(pend_addr);
            mem_rdata_valid = 1'b1;
            pending         = 1'b0;
         end else begin
            delay = delay - 1;
         end
      end
      if (mem_ce) begin
         if (pending) begin
            report_failure("mem_ce raised while a memory read was outstanding");
         end else begin
            pending   = 1'b1;
            pend_addr = mem_addr;
            delay     = 1 + ({$random(seed)} % 4);
            seen_addr.push_back(mem_addr);
         end
      end
   end

   task automatic check_idle(input string when);
      if (!ready || rdata_valid || mem_ce) begin
         report_failure({"cache outputs not idle ", when});
      end
   endtask

   // called at a falling edge
   task automatic wait_ready();
      int waited;
      waited = 0;
      while (!ready) begin
         @(negedge clk);
         waited++;
         if (waited > wait_limit) report_failure("ready stayed low");
      end
   endtask

   // called at a falling edge; latency counts rising edges from acceptance to rdata_valid
   task automatic read_word(input addr_t a, output word_t data, output int latency);
      wait_ready();
      seen_addr.delete();
      ce      = 1'b1;
      addr    = a;
      latency = 0;
      do begin
         @(negedge clk);
         ce = 1'b0;
         latency++;
         if (latency > wait_limit) report_failure("no rdata_valid for an accepted request");
      end while (!rdata_valid);
      data = rdata;
   endtask

   task automatic expect_hit(input addr_t a);
      word_t data;
      int    latency;
      read_word(a, data, latency);
      check_word($sformatf("rdata for %h", a), data, mem_word(a));
      check_count("hit latency", latency, 2);
      check_count("mem_ce pulses on hit", seen_addr.size(), 0);
   endtask

   task automatic expect_miss(input addr_t a);
      word_t data;
      int    latency;
      read_word(a, data, latency);
      check_word($sformatf("rdata for %h", a), data, mem_word(a));
      check_count("mem_ce pulses on miss", seen_addr.size(), 4);
      for (int i = 0; i < seen_addr.size(); i++) begin
         check_addr("mem_addr", seen_addr[i], (a & ~addr_t'('hF)) + addr_t'(4 * i)); // 16-byte line
      end
   endtask

   task automatic cold_miss();
      expect_miss(32'h0000_1234); // word 1 of the line
   endtask

   task automatic line_hits();
      expect_hit(32'h0000_1230);
      expect_hit(32'h0000_1238);
      expect_hit(32'h0000_123C);
   endtask

   // set 5, ends with 4050 most recent
   task automatic two_tags_resident();
      expect_miss(32'h0000_2050);
      expect_miss(32'h0000_4050);
      for (int i = 0; i < 2; i++) begin
         expect_hit(32'h0000_2050);
         expect_hit(32'h0000_4050);
      end
   endtask

   task automatic lru_eviction();
      expect_miss(32'h0000_8050); // replaces 2050, the older one
      expect_hit(32'h0000_4050);
      expect_miss(32'h0000_2050);
   endtask

   task automatic back_pressure();
      addr_t a;
      word_t held;
      int    latency;
      a           = 32'h0000_1238;
      wait_ready(); // earlier response taken first
      rdata_ready = 1'b0;
      read_word(a, held, latency);
      check_count("hit latency", latency, 2);
      for (int i = 0; i < 6; i++) begin
         @(negedge clk);
         if (!rdata_valid) report_failure("rdata_valid dropped while rdata_ready was low");
         if (ready) report_failure("ready high while a response was pending");
         check_word("rdata under back-pressure", rdata, held);
      end
      rdata_ready = 1'b1;
      @(negedge clk);
      if (rdata_valid) report_failure("response not released after rdata_ready");
      check_word("rdata after back-pressure", held, mem_word(a));
   endtask

   task automatic reset_invalidates();
      reset_req = 1'b1;
      repeat (2) @(negedge clk);
      reset_req = 1'b0;
      @(negedge clk);
      check_idle("after second reset");
      expect_miss(32'h0000_1230);
   endtask

   initial begin
      int waited;
      waited = 0;
      @(negedge clk);
      while (reset) begin
         @(negedge clk);
         waited++;
         if (waited > wait_limit) report_failure("reset never released");
      end
      check_idle("after reset");
      rdata_ready = 1'b1;
      cold_miss();
      line_hits();
      two_tags_resident();
      lru_eviction();
      back_pressure();
      reset_invalidates();
      @(negedge clk);
      if (icache_top_i.assertions_i.fail_count == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         report_failure("assertion failures during the run");
      end
   end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/sram_array.sv
rtl/cache_lookup.sv
rtl/cache_hit_select.sv
rtl/cache_refill.sv
rtl/icache_top.sv
sim/clock_gen.sv
sim/icache_assertions.sv
sim/icache_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vicache_tb
SRCS := $(filter-out +incdir+%,$(shell cat sources.f)) rtl/cache_settings.svh

.PHONY: all run clean

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f sources.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
